// ==== frame_decoder_pkg.sv ====
package frame_decoder_pkg;

    // ------------------------------------------------------------------------
    // sizes and limits
    // ------------------------------------------------------------------------

    localparam int num_ports = 10;
    localparam int data_w = 32;
    localparam int keep_w = 4;
    localparam int level_w = 32;

    localparam logic [level_w-1:0] ecn_alert_threshold = 3000;
    localparam logic [7:0] ecn_mark = 8'd1;

    // port n answers to label_base + n
    localparam logic [7:0] label_base = 8'd1;

    // DA, DA/SA, SA, then the tag word
    localparam int tag_word_index = 3;

    // counts up to one past the tag word, then holds
    localparam int beat_cnt_w = $clog2(tag_word_index + 2);

    // aligner buffer holds the three header beats of a waiting frame
    localparam int align_addr_w = 2;
    localparam int align_fifo_depth = 1 << align_addr_w;

    // ------------------------------------------------------------------------
    // stream and route types
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [keep_w-1:0] keep;
        logic              last;
    } axis_beat_t;

    // lane 3 label, lane 2 ecn, lanes 1..0 length/type
    typedef struct packed {
        logic [7:0]  label;
        logic [7:0]  ecn;
        logic [15:0] length_type;
    } tag_fields_t;

    typedef union packed {
        logic [data_w-1:0] raw;
        tag_fields_t       fields;
    } tag_word_u;

    typedef logic [num_ports-1:0] port_sel_t;

    typedef logic [num_ports-1:0][level_w-1:0] fifo_levels_t;

    typedef struct packed {
        port_sel_t  sel;
        logic [7:0] ecn;
    } route_info_t;

endpackage

// ==== payload_aligner.sv ====
`timescale 1ns/10ps

module payload_aligner import frame_decoder_pkg::*; (
    input  logic       glb_clk,
    input  logic       glb_areset_n,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t aligned_beat,
    output logic       aligned_valid,
    input  logic       aligned_ready,
    output tag_word_u  tag_word,
    output logic       tag_valid,
    input  logic       tag_ready
);

    axis_beat_t            fifo_mem [align_fifo_depth];
    logic [align_addr_w:0] wr_ptr;
    logic [align_addr_w:0] rd_ptr;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic                  push;
    logic                  pop;
    axis_beat_t            push_beat;

    logic [beat_cnt_w-1:0] beat_cnt;
    logic                  at_head;
    logic                  at_tag;
    logic                  in_fire;
    logic                  running;
    logic                  flush_pending;
    logic                  tag_seen;
    logic [data_w-9:0]     carry_data;
    logic [keep_w-1:0]     carry_keep;

    // ------------------------------------------------------------------------
    // input side
    // ------------------------------------------------------------------------

    assign at_head = beat_cnt < beat_cnt_w'(tag_word_index);
    assign at_tag  = beat_cnt == beat_cnt_w'(tag_word_index);

    always_comb begin
        if (!running || flush_pending) begin
            in_ready = 1'b0;
        end else if (at_tag) begin
            // tag beat waits for the classifier and takes no buffer slot
            in_ready = tag_ready;
        end else begin
            in_ready = !fifo_full;
        end
    end

    assign in_fire   = in_valid && in_ready;
    assign tag_word.raw = in_beat.data;
    assign tag_valid = in_valid && at_tag;

    // header beats pass, later beats shift down by one byte
    always_comb begin
        push_beat = in_beat;
        push      = 1'b0;
        if (flush_pending) begin
            push           = !fifo_full;
            push_beat.data = {8'h00, carry_data};
            push_beat.keep = carry_keep;
            push_beat.last = 1'b1;
        end else if (in_fire && !at_tag) begin
            push = 1'b1;
            if (!at_head) begin
                push_beat.data = {in_beat.data[7:0], carry_data};
                push_beat.keep = '1;
                // one byte in the last beat closes the frame here
                push_beat.last = in_beat.last && !in_beat.keep[1];
            end
        end
    end

    // ------------------------------------------------------------------------
    // output buffer
    // ------------------------------------------------------------------------

    assign fifo_empty = wr_ptr == rd_ptr;
    assign fifo_full  = (wr_ptr[align_addr_w] != rd_ptr[align_addr_w]) &&
                        (wr_ptr[align_addr_w-1:0] == rd_ptr[align_addr_w-1:0]);

    assign aligned_valid = !fifo_empty;
    assign aligned_beat  = fifo_mem[rd_ptr[align_addr_w-1:0]];
    assign pop           = aligned_valid && aligned_ready;

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            running       <= 1'b0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            beat_cnt      <= '0;
            flush_pending <= 1'b0;
            tag_seen      <= 1'b0;
        end else begin
            running <= 1'b1;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (flush_pending && push) begin
                flush_pending <= 1'b0;
            end
            if (in_fire) begin
                if (in_beat.last) begin
                    beat_cnt      <= '0;
                    tag_seen      <= 1'b0;
                    flush_pending <= in_beat.keep[1];
                end else begin
                    if (beat_cnt != beat_cnt_w'(tag_word_index + 1)) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (at_tag) begin
                        tag_seen <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge glb_clk) begin
        if (push) begin
            fifo_mem[wr_ptr[align_addr_w-1:0]] <= push_beat;
        end
        if (in_fire && !at_head) begin
            // the label byte is not kept
            if (at_tag) begin
                carry_data <= tag_word.raw[data_w-9:0];
            end else begin
                carry_data <= in_beat.data[data_w-1:8];
            end
            carry_keep <= {1'b0, in_beat.keep[keep_w-1:1]};
        end
    end

    a_in_stable: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        in_valid && !in_ready |=> in_valid && $stable(in_beat))
        else $error("input beat changed while stalled");

    a_tag_once: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        tag_valid && tag_ready |-> !tag_seen)
        else $error("tag word presented twice in one frame");

endmodule

// ==== route_classifier.sv ====
`timescale 1ns/10ps

module route_classifier import frame_decoder_pkg::*; (
    input  logic         glb_clk,
    input  logic         glb_areset_n,
    input  tag_word_u    tag_word,
    input  logic         tag_valid,
    output logic         tag_ready,
    input  fifo_levels_t fifo_levels,
    input  logic         route_done,
    output route_info_t  route,
    output logic         route_valid
);

    port_sel_t  sel_next;
    port_sel_t  over_level;
    logic [7:0] ecn_next;
    logic       tag_fire;

    // one route at a time
    assign tag_ready = !route_valid;
    assign tag_fire  = tag_valid && tag_ready;

    // ------------------------------------------------------------------------
    // label decode and congestion check
    // ------------------------------------------------------------------------

    always_comb begin
        for (int n = 0; n < num_ports; n++) begin
            sel_next[n]   = tag_word.fields.label == label_base + 8'(n);
            over_level[n] = fifo_levels[n] > ecn_alert_threshold;
        end
    end

    // unknown labels match no port, so ecn passes through
    assign ecn_next = |(sel_next & over_level) ? ecn_mark : tag_word.fields.ecn;

    // ------------------------------------------------------------------------
    // route hold
    // ------------------------------------------------------------------------

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            route_valid <= 1'b0;
        end else if (tag_fire) begin
            route_valid <= 1'b1;
        end else if (route_done) begin
            route_valid <= 1'b0;
        end
    end

    always_ff @(posedge glb_clk) begin
        if (tag_fire) begin
            route <= '{sel: sel_next, ecn: ecn_next};
        end
    end

    a_sel_onehot: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        route_valid |-> $onehot0(route.sel))
        else $error("port select has more than one bit set");

endmodule

// ==== frame_emitter.sv ====
`timescale 1ns/10ps

module frame_emitter import frame_decoder_pkg::*; (
    input  logic        glb_clk,
    input  logic        glb_areset_n,
    input  axis_beat_t  aligned_beat,
    input  logic        aligned_valid,
    output logic        aligned_ready,
    input  route_info_t route,
    input  logic        route_valid,
    output logic        route_done,
    output axis_beat_t  out_beat,
    output logic        out_valid,
    input  logic        out_ready,
    output port_sel_t   port_sel
);

    logic [beat_cnt_w-1:0] beat_cnt;
    logic                  frame_closed;
    logic                  take;
    axis_beat_t            patched_beat;

    // ------------------------------------------------------------------------
    // stream gating
    // ------------------------------------------------------------------------

    // beats after the last one belong to the next frame and its route
    assign aligned_ready = route_valid && !frame_closed && (!out_valid || out_ready);
    assign take          = aligned_valid && aligned_ready;

    assign route_done = out_valid && out_ready && out_beat.last;
    assign port_sel   = route_valid ? route.sel : '0;

    // ecn sits in lane 2 of the tag word
    always_comb begin
        patched_beat = aligned_beat;
        if (beat_cnt == beat_cnt_w'(tag_word_index)) begin
            patched_beat.data[2*8 +: 8] = route.ecn;
        end
    end

    // ------------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------------

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            out_valid    <= 1'b0;
            beat_cnt     <= '0;
            frame_closed <= 1'b0;
        end else begin
            if (take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end

            if (take && aligned_beat.last) begin
                frame_closed <= 1'b1;
            end else if (route_done) begin
                frame_closed <= 1'b0;
            end

            if (take) begin
                if (aligned_beat.last) begin
                    beat_cnt <= '0;
                end else if (beat_cnt != beat_cnt_w'(tag_word_index + 1)) begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge glb_clk) begin
        if (take) begin
            out_beat <= patched_beat;
        end
    end

    a_out_stable: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed while stalled");

endmodule

// ==== frame_decoder_top.sv ====
`timescale 1ns/10ps

module frame_decoder_top import frame_decoder_pkg::*; (
    input  logic         glb_clk,
    input  logic         glb_areset_n,
    input  axis_beat_t   in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output axis_beat_t   out_beat,
    output logic         out_valid,
    input  logic         out_ready,
    input  fifo_levels_t fifo_levels,
    output port_sel_t    port_sel
);

    axis_beat_t  aligned_beat;
    logic        aligned_valid;
    logic        aligned_ready;
    tag_word_u   tag_word;
    logic        tag_valid;
    logic        tag_ready;
    route_info_t route;
    logic        route_valid;
    logic        route_done;

    // ------------------------------------------------------------------------
    // aligner and classifier side by side, emitter joins them
    // ------------------------------------------------------------------------

    payload_aligner payload_aligner_inst (
        .glb_clk       (glb_clk),
        .glb_areset_n  (glb_areset_n),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .aligned_beat  (aligned_beat),
        .aligned_valid (aligned_valid),
        .aligned_ready (aligned_ready),
        .tag_word      (tag_word),
        .tag_valid     (tag_valid),
        .tag_ready     (tag_ready)
    );

    route_classifier route_classifier_inst (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .tag_word     (tag_word),
        .tag_valid    (tag_valid),
        .tag_ready    (tag_ready),
        .fifo_levels  (fifo_levels),
        .route_done   (route_done),
        .route        (route),
        .route_valid  (route_valid)
    );

    frame_emitter frame_emitter_inst (
        .glb_clk       (glb_clk),
        .glb_areset_n  (glb_areset_n),
        .aligned_beat  (aligned_beat),
        .aligned_valid (aligned_valid),
        .aligned_ready (aligned_ready),
        .route         (route),
        .route_valid   (route_valid),
        .route_done    (route_done),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .port_sel      (port_sel)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic glb_clk,
    output logic glb_areset_n
);

    // 8 ns period
    initial begin
        glb_clk = 1'b0;
        forever #4 glb_clk = ~glb_clk;
    end

    initial begin
        glb_areset_n = 1'b0;
        repeat (16) @(posedge glb_clk);
        #1 glb_areset_n = 1'b1;
    end

endmodule

// ==== frame_decoder_tb.sv ====
`timescale 1ns/10ps

module frame_decoder_tb import frame_decoder_pkg::*; ();

    localparam int max_tests = 16;
    localparam int max_beats = 256;
    localparam int cycles_per_beat = 200;

    logic         glb_clk;
    logic         glb_areset_n;
    axis_beat_t   in_beat;
    logic         in_valid;
    logic         in_ready;
    axis_beat_t   out_beat;
    logic         out_valid;
    logic         out_ready;
    fifo_levels_t fifo_levels;
    port_sel_t    port_sel;

    string        test_name [max_tests];
    fifo_levels_t test_levels [max_tests];
    port_sel_t    test_sel [max_tests];
    int           in_count [max_tests];
    int           out_count [max_tests];
    axis_beat_t   in_beats [max_beats];
    axis_beat_t   exp_beats [max_beats];
    int           num_tests = 0;
    int           total_in = 0;
    int           total_out = 0;
    int           error_count = 0;
    int           watchdog_limit = 0;

    tb_clock_gen tb_clock_gen_inst (.*);

    frame_decoder_top frame_decoder_top_inst (.*);

    task automatic compare_value(input string name, input string field,
                                 input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("mismatch %s %s: expected %0h, actual %0h", name, field, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------------
    // golden file
    // ------------------------------------------------------------------------

    task automatic load_golden();
        int                 fd;
        int                 code;
        int                 nin;
        int                 nout;
        int                 last_bit;
        string              tok;
        string              name;
        port_sel_t          sel;
        logic [level_w-1:0] level;
        logic [data_w-1:0]  data;
        logic [keep_w-1:0]  keep;
        fd = $fopen("frame_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file frame_golden.txt");
            error_count++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                code = $fgets(tok, fd);
                continue;
            end
            code = $fscanf(fd, "%s %d %d %h", name, nin, nout, sel);
            if (tok != "test" || code != 4 || num_tests == max_tests) begin
                $display("golden file is malformed near %s", tok);
                error_count++;
                break;
            end
            test_name[num_tests] = name;
            test_sel[num_tests]  = sel;
            in_count[num_tests]  = nin;
            out_count[num_tests] = nout;
            for (int n = 0; n < num_ports; n++) begin
                code = $fscanf(fd, "%d", level);
                test_levels[num_tests][n] = level;
            end
            for (int i = 0; i < nin + nout; i++) begin
                code = $fscanf(fd, "%h %h %d", data, keep, last_bit);
                if (code != 3) begin
                    $display("golden file has a short beat list in test %s", name);
                    error_count++;
                end
                if (i < nin) begin
                    in_beats[total_in] = '{data, keep, last_bit[0]};
                    total_in++;
                end else begin
                    exp_beats[total_out] = '{data, keep, last_bit[0]};
                    total_out++;
                end
            end
            num_tests++;
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------------------
    // stimulus and checking
    // ------------------------------------------------------------------------

    task automatic drive_frames();
        int beat_idx;
        beat_idx = 0;
        for (int t = 0; t < num_tests; t++) begin
            // sampled when this frame's tag word is classified
            fifo_levels = test_levels[t];
            for (int i = 0; i < in_count[t]; i++) begin
                in_beat  = in_beats[beat_idx];
                in_valid = 1'b1;
                @(negedge glb_clk);
                while (!in_ready) begin
                    @(negedge glb_clk);
                end
                @(posedge glb_clk);
                #1;
                beat_idx++;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_frames();
        int                t;
        int                k;
        int                got;
        string             name;
        axis_beat_t        exp_b;
        logic [data_w-1:0] mask;
        t   = 0;
        k   = 0;
        got = 0;
        while (got < total_out) begin
            @(negedge glb_clk);
            if (out_valid && out_ready) begin
                name  = test_name[t];
                exp_b = exp_beats[got];
                for (int lane = 0; lane < keep_w; lane++) begin
                    mask[lane*8 +: 8] = {8{exp_b.keep[lane]}};
                end
                compare_value(name, "data", 64'(exp_b.data & mask),
                              64'(out_beat.data & mask));
                compare_value(name, "keep", 64'(exp_b.keep), 64'(out_beat.keep));
                compare_value(name, "last", 64'(exp_b.last), 64'(out_beat.last));
                compare_value(name, "port_sel", 64'(test_sel[t]), 64'(port_sel));
                got++;
                k++;
                if (k == out_count[t]) begin
                    // select clears one cycle after the last transfer
                    @(negedge glb_clk);
                    compare_value(name, "idle port_sel", 64'd0, 64'(port_sel));
                    k = 0;
                    t++;
                end
            end
        end
    endtask

    initial begin
        int extra_cycles;
        extra_cycles = 0;
        in_beat      = '0;
        in_valid     = 1'b0;
        fifo_levels  = '0;
        load_golden();
        if (error_count == 0 && num_tests == 0) begin
            $display("golden file holds no tests");
            error_count++;
        end
        if (error_count == 0) begin
            watchdog_limit = cycles_per_beat * (total_in + total_out);
            wait (glb_areset_n);
            @(posedge glb_clk);
            #1;
            fork
                drive_frames();
                collect_frames();
            join
            repeat (20) begin
                @(negedge glb_clk);
                if (out_valid) begin
                    extra_cycles++;
                end
            end
            if (extra_cycles != 0) begin
                $display("output stayed valid after the last expected beat");
                error_count++;
            end
        end
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // sink ready about three cycles in four
    initial begin
        out_ready = 1'b0;
        void'($urandom(32'h2f51d27b));
        wait (glb_areset_n);
        forever begin
            @(posedge glb_clk);
            #1;
            out_ready = ($urandom % 4) != 0;
        end
    end

    initial begin
        wait (watchdog_limit > 0);
        repeat (watchdog_limit) @(posedge glb_clk);
        error_count++;
        $display("timeout, frames did not drain within %0d cycles", watchdog_limit);
        $display("errors: %0d", error_count);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== frame_golden.txt ====
# test <name> <input beats> <output beats> <port_sel hex>, then ten fill levels from port 0,
# then the input beats and the expected output beats as <data hex> <keep hex> <last>
test port3_low 5 5 008
100 100 100 100 100 100 100 100 100 100
03020100 f 0 07060504 f 0 0b0a0908 f 0 04020d0c f 0 13121110 f 1
03020100 f 0 07060504 f 0 0b0a0908 f 0 10020d0c f 0 00131211 7 1
test port7_mark 5 5 080
0 0 0 0 0 0 0 3001 0 0
23222120 f 0 27262524 f 0 2b2a2928 f 0 08032d2c f 0 33323130 f 1
23222120 f 0 27262524 f 0 2b2a2928 f 0 30012d2c f 0 00333231 7 1
test port7_edge_keep1 6 5 080
0 0 0 0 0 0 0 3000 0 0
43424140 f 0 47464544 f 0 4b4a4948 f 0 08034d4c f 0 53525150 f 0 00000054 1 1
43424140 f 0 47464544 f 0 4b4a4948 f 0 50034d4c f 0 54535251 f 1
test bad_label_keep2 6 6 000
5000 5000 5000 5000 5000 5000 5000 5000 5000 5000
63626160 f 0 67666564 f 0 6b6a6968 f 0 fe026d6c f 0 73727170 f 0 00007574 3 1
63626160 f 0 67666564 f 0 6b6a6968 f 0 70026d6c f 0 74737271 f 0 00000075 1 1
test port0_mark_keep3 6 6 001
3001 0 0 0 0 0 0 0 0 0
83828180 f 0 87868584 f 0 8b8a8988 f 0 01008d8c f 0 93929190 f 0 00969594 7 1
83828180 f 0 87868584 f 0 8b8a8988 f 0 90018d8c f 0 94939291 f 0 00009695 3 1

// ==== all.f ====
frame_decoder_pkg.sv
payload_aligner.sv
route_classifier.sv
frame_emitter.sv
frame_decoder_top.sv
tb_clock_gen.sv
frame_decoder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the frame decoder testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module frame_decoder_tb \
        -o frame_decoder_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/frame_decoder_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
